// ==== design/csr_pkg.sv ====
// Machine CSR definitions
package csr_pkg;

	typedef logic [31:0] csr_word_t;
	typedef logic [11:0] csr_index_t;

	// Machine trap setup and handling.
	localparam csr_index_t CSR_MSTATUS = 12'h300;
	localparam csr_index_t CSR_MIE = 12'h304;
	localparam csr_index_t CSR_MTVEC = 12'h305;
	localparam csr_index_t CSR_MSCRATCH = 12'h340;
	localparam csr_index_t CSR_MEPC = 12'h341;
	localparam csr_index_t CSR_MCAUSE = 12'h342;
	localparam csr_index_t CSR_MIP = 12'h344;

	// User-level counters.
	localparam csr_index_t CSR_CYCLE = 12'hC00;
	localparam csr_index_t CSR_CYCLEH = 12'hC80;
	localparam csr_index_t CSR_TIME = 12'hC01;
	localparam csr_index_t CSR_TIMEH = 12'hC81;
	localparam csr_index_t CSR_INSTRET = 12'hC02;
	localparam csr_index_t CSR_INSTRETH = 12'hC82;

	// Machine identity.
	localparam csr_index_t CSR_MVENDORID = 12'hF11;
	localparam csr_index_t CSR_MARCHID = 12'hF12;
	localparam csr_index_t CSR_MIMPID = 12'hF13;
	localparam csr_index_t CSR_MHARTID = 12'hF14;

	// Interrupt causes.
	localparam csr_word_t CAUSE_EXTERNAL = 32'h8000_0800;
	localparam csr_word_t CAUSE_TIMER = 32'h8000_0080;
	// Software cause keeps the legacy encoding, interrupt bit clear.
	localparam csr_word_t CAUSE_SOFTWARE = 32'h0000_0800;

	// Bit positions in mie and mip.
	localparam int BIT_MEI = 11;
	localparam int BIT_MTI = 7;
	localparam int BIT_MSI = 3;

	// Bit positions in mstatus.
	localparam int BIT_MIE = 3;
	localparam int BIT_MPIE = 4;

endpackage

// ==== design/csr_irq_if.sv ====
// Interrupt control bus
`timescale 1ns/1ns

interface csr_irq_if
	import csr_pkg::*;
();
	// Enables, mirrored from mie and mstatus.
	logic enable_mei;
	logic enable_mti;
	logic enable_msi;
	logic global_enable;

	// Software write to mip, ordered {MEI, MTI, MSI}.
	logic mip_write;
	logic [2:0] mip_wdata;

	// Pending state and issue, same bit order.
	logic [2:0] mip_value;
	logic take;
	csr_word_t take_cause;

	modport regs (
		output enable_mei, enable_mti, enable_msi, global_enable,
		output mip_write, mip_wdata,
		input mip_value, take, take_cause
	);

	modport irq (
		input enable_mei, enable_mti, enable_msi, global_enable,
		input mip_write, mip_wdata,
		output mip_value, take, take_cause
	);

endinterface

// ==== design/csr_counters.sv ====
// Cycle and wall-time counters
`timescale 1ns/1ns

module csr_counters #(
	parameter int FREQUENCY = 50_000_000
)(
	input logic i_clock,
	input logic i_reset,
	output logic [63:0] o_cycle_count,
	output logic [63:0] o_time_count
);
	// Prescaler runs 0 to PRESCALE, one millisecond per wrap.
	localparam int PRESCALE = FREQUENCY / 1000;
	localparam int PRESCALE_WIDTH = $clog2(PRESCALE + 1);

	logic [PRESCALE_WIDTH - 1:0] prescale;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cycle_count <= 64'd0;
		end else begin
			o_cycle_count <= o_cycle_count + 64'd1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			prescale <= '0;
			o_time_count <= 64'd0;
		end else if (prescale == PRESCALE_WIDTH'(PRESCALE)) begin
			prescale <= '0;
			o_time_count <= o_time_count + 64'd1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

// ==== design/csr_interrupt_unit.sv ====
// Interrupt pending and issue logic
`timescale 1ns/1ns

module csr_interrupt_unit
	import csr_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_irq_dispatched,
	csr_irq_if.irq port_irq,
	output logic o_irq_pending
);
	// All vectors ordered {MEI, MTI, MSI}.
	logic [2:0] pending;
	logic [2:0] pending_next;
	logic [2:0] issued;
	logic [2:0] enables;
	logic [2:0] raised;
	logic [2:0] ready;
	logic [2:0] select;
	csr_word_t cause;
	logic take;

	assign enables = {port_irq.enable_mei, port_irq.enable_mti, port_irq.enable_msi};

	// Sources only latch while their mie bit is set.
	assign raised = {i_external_interrupt, i_timer_interrupt, i_ecall} & enables;
	assign ready = pending & enables;

	// Fixed priority, external over timer over software.
	always_comb begin
		select = 3'b000;
		cause = '0;
		if (ready[2]) begin
			select = 3'b100;
			cause = CAUSE_EXTERNAL;
		end else if (ready[1]) begin
			select = 3'b010;
			cause = CAUSE_TIMER;
		end else if (ready[0]) begin
			select = 3'b001;
			cause = CAUSE_SOFTWARE;
		end
	end

	// One issue per pending window.
	assign take = !o_irq_pending && port_irq.global_enable && (|ready);

	assign port_irq.take = take;
	assign port_irq.take_cause = cause;
	assign port_irq.mip_value = pending;

	// Hardware latch wins over a software write in the same cycle.
	always_comb begin
		pending_next = pending;
		if (port_irq.mip_write) begin
			pending_next = port_irq.mip_wdata;
		end
		pending_next = pending_next | raised;
		if (i_irq_dispatched) begin
			pending_next = pending_next & ~issued;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			pending <= 3'b000;
		end else begin
			pending <= pending_next;
		end
	end

	// Issued source and pending flag, closed by dispatch.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			issued <= 3'b000;
			o_irq_pending <= 1'b0;
		end else begin
			if (take) begin
				issued <= select;
				o_irq_pending <= 1'b1;
			end
			if (i_irq_dispatched) begin
				issued <= 3'b000;
				o_irq_pending <= 1'b0;
			end
		end
	end

endmodule

// ==== design/csr_register_file.sv ====
// Machine CSR storage and access
`timescale 1ns/1ns

module csr_register_file
	import csr_pkg::*;
#(
	parameter csr_word_t VENDORID = 32'h0,
	parameter csr_word_t ARCHID = 32'h0,
	parameter csr_word_t IMPID = 32'h0,
	parameter csr_word_t HARTID = 32'h0
)(
	input logic i_clock,
	input logic i_reset,

	// Instruction access.
	input csr_index_t i_index,
	input logic i_wdata_wr,
	input csr_word_t i_wdata,
	output csr_word_t o_rdata,

	// Trap addresses.
	output csr_word_t o_epc,
	output csr_word_t o_irq_pc,

	// Pipeline events.
	input logic i_mret,
	input logic i_irq_dispatched,
	input csr_word_t i_irq_epc,

	// Counter sources.
	input logic [63:0] i_retired,
	input logic [63:0] i_cycle_count,
	input logic [63:0] i_time_count,

	csr_irq_if.regs port_regs
);
	logic mstatus_mie;
	logic mstatus_mpie;
	logic mie_meie;
	logic mie_mtie;
	logic mie_msie;
	csr_word_t mtvec;
	csr_word_t mscratch;
	csr_word_t mepc;
	csr_word_t mcause;

	csr_word_t mstatus_word;
	csr_word_t mie_word;
	csr_word_t mip_word;

	assign o_epc = mepc;

	// Levels seen by the interrupt unit.
	assign port_regs.enable_mei = mie_meie;
	assign port_regs.enable_mti = mie_mtie;
	assign port_regs.enable_msi = mie_msie;
	assign port_regs.global_enable = mstatus_mie;

	// mip lives in the interrupt unit, writes go over as a strobe.
	assign port_regs.mip_write = i_wdata_wr && (i_index == CSR_MIP);
	assign port_regs.mip_wdata = {i_wdata[BIT_MEI], i_wdata[BIT_MTI], i_wdata[BIT_MSI]};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mstatus_mie <= 1'b0;
			mstatus_mpie <= 1'b0;
			mie_meie <= 1'b1;
			mie_mtie <= 1'b1;
			mie_msie <= 1'b1;
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
		end else begin
			if (i_wdata_wr) begin
				case (i_index)
					CSR_MSTATUS: mstatus_mie <= i_wdata[BIT_MIE];
					CSR_MIE: begin
						mie_meie <= i_wdata[BIT_MEI];
						mie_mtie <= i_wdata[BIT_MTI];
						mie_msie <= i_wdata[BIT_MSI];
					end
					CSR_MTVEC: mtvec <= i_wdata;
					CSR_MSCRATCH: mscratch <= i_wdata;
					CSR_MEPC: mepc <= i_wdata;
					default: ;
				endcase
			end

			// Push MIE on issue.
			if (port_regs.take) begin
				mcause <= port_regs.take_cause;
				mstatus_mpie <= mstatus_mie;
				mstatus_mie <= 1'b0;
			end

			// Pop MIE on return.
			if (i_mret) begin
				mstatus_mie <= mstatus_mpie;
				mstatus_mpie <= 1'b0;
			end

			if (i_irq_dispatched) begin
				mepc <= i_irq_epc;
			end
		end
	end

	// Handler address, captured at issue.
	always_ff @(posedge i_clock) begin
		if (port_regs.take) begin
			o_irq_pc <= mtvec;
		end
	end

	// Assemble the bit-field registers.
	always_comb begin
		mstatus_word = '0;
		mstatus_word[BIT_MIE] = mstatus_mie;
		mstatus_word[BIT_MPIE] = mstatus_mpie;

		mie_word = '0;
		mie_word[BIT_MEI] = mie_meie;
		mie_word[BIT_MTI] = mie_mtie;
		mie_word[BIT_MSI] = mie_msie;

		mip_word = '0;
		mip_word[BIT_MEI] = port_regs.mip_value[2];
		mip_word[BIT_MTI] = port_regs.mip_value[1];
		mip_word[BIT_MSI] = port_regs.mip_value[0];
	end

	// Read mux, unknown indices read zero.
	always_comb begin
		case (i_index)
			CSR_MSTATUS: o_rdata = mstatus_word;
			CSR_MIE: o_rdata = mie_word;
			CSR_MTVEC: o_rdata = mtvec;
			CSR_MSCRATCH: o_rdata = mscratch;
			CSR_MEPC: o_rdata = mepc;
			CSR_MCAUSE: o_rdata = mcause;
			CSR_MIP: o_rdata = mip_word;
			CSR_CYCLE: o_rdata = i_cycle_count[31:0];
			CSR_CYCLEH: o_rdata = i_cycle_count[63:32];
			CSR_TIME: o_rdata = i_time_count[31:0];
			CSR_TIMEH: o_rdata = i_time_count[63:32];
			CSR_INSTRET: o_rdata = i_retired[31:0];
			CSR_INSTRETH: o_rdata = i_retired[63:32];
			CSR_MVENDORID: o_rdata = VENDORID;
			CSR_MARCHID: o_rdata = ARCHID;
			CSR_MIMPID: o_rdata = IMPID;
			CSR_MHARTID: o_rdata = HARTID;
			default: o_rdata = '0;
		endcase
	end

endmodule

// ==== design/machine_csr.sv ====
// Machine CSR block
`timescale 1ns/1ns

module machine_csr
	import csr_pkg::*;
#(
	parameter int FREQUENCY = 50_000_000,
	parameter csr_word_t VENDORID = 32'h0,
	parameter csr_word_t ARCHID = 32'h0,
	parameter csr_word_t IMPID = 32'h0,
	parameter csr_word_t HARTID = 32'h0
)(
	input logic i_reset,
	input logic i_clock,

	// Interrupt sources.
	input logic i_timer_interrupt,
	input logic i_external_interrupt,
	input logic i_ecall,
	input logic i_mret,

	// Instruction access.
	input csr_index_t i_index,
	output csr_word_t o_rdata,
	input logic i_wdata_wr,
	input csr_word_t i_wdata,

	output csr_word_t o_epc,

	// Interrupt request to the pipeline.
	output logic o_irq_pending,
	output csr_word_t o_irq_pc,
	input logic i_irq_dispatched,
	input csr_word_t i_irq_epc,

	input logic [63:0] i_retired
);
	logic [63:0] cycle_count;
	logic [63:0] time_count;

	csr_irq_if irq_bus ();

	csr_counters #(
		.FREQUENCY(FREQUENCY)
	) u_counters (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_cycle_count(cycle_count),
		.o_time_count(time_count)
	);

	csr_interrupt_unit u_interrupt_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_timer_interrupt(i_timer_interrupt),
		.i_external_interrupt(i_external_interrupt),
		.i_ecall(i_ecall),
		.i_irq_dispatched(i_irq_dispatched),
		.port_irq(irq_bus.irq),
		.o_irq_pending(o_irq_pending)
	);

	csr_register_file #(
		.VENDORID(VENDORID),
		.ARCHID(ARCHID),
		.IMPID(IMPID),
		.HARTID(HARTID)
	) u_register_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_index(i_index),
		.i_wdata_wr(i_wdata_wr),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_epc(o_epc),
		.o_irq_pc(o_irq_pc),
		.i_mret(i_mret),
		.i_irq_dispatched(i_irq_dispatched),
		.i_irq_epc(i_irq_epc),
		.i_retired(i_retired),
		.i_cycle_count(cycle_count),
		.i_time_count(time_count),
		.port_regs(irq_bus.regs)
	);

endmodule

// ==== verif/csr_checker.sv ====
// CSR response checker
`timescale 1ns/1ns

module csr_checker #(
	parameter int FREQUENCY = 4000
)(
	input logic i_clock,
	input logic i_reset,
	input logic [31:0] i_rdata,
	input logic [31:0] i_epc,
	input logic [31:0] i_irq_pc,
	input logic i_irq_pending,
	input logic i_check_valid,
	input logic [2:0] i_check_kind,
	input logic [31:0] i_check_data,
	input logic [31:0] i_check_expected,
	input logic [127:0] i_check_name,
	output int o_error_count,
	output int o_check_count
);
	// One millisecond tick per prescaler wrap.
	localparam int TICK_CYCLES = FREQUENCY / 1000 + 1;

	logic [63:0] cycles;
	logic [63:0] wall_ticks;

	initial begin
		o_error_count = 0;
		o_check_count = 0;
	end

	// Cycles since reset.
	always @(posedge i_clock) begin
		if (i_reset) begin
			cycles <= 64'd0;
		end else begin
			cycles <= cycles + 64'd1;
		end
	end

	assign wall_ticks = cycles / TICK_CYCLES;

	task automatic compare(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		o_check_count++;
		if (actual !== expected) begin
			o_error_count++;
			$display("ERR %0s %0s expected %h actual %h", i_check_name, field, expected, actual);
		end
	endtask

	// Outputs have settled by the falling edge.
	always @(negedge i_clock) begin
		if (i_check_valid) begin
			case (i_check_kind)
				3'd0: compare("rdata", i_check_expected, i_rdata);
				3'd1: compare("cycle", cycles[31:0], i_rdata);
				3'd2: compare("time", wall_ticks[31:0], i_rdata);
				3'd3: begin
					compare("irq_pc", i_check_data, i_irq_pc);
					compare("rdata", i_check_expected, i_rdata);
				end
				3'd4: begin
					compare("epc", i_check_data, i_epc);
					compare("rdata", i_check_expected, i_rdata);
					compare("pending", 32'd0, {31'd0, i_irq_pending});
				end
				3'd5: compare("pending", {31'd0, i_check_expected[0]}, {31'd0, i_irq_pending});
				default: begin
					o_error_count++;
					$display("Check request with unknown kind %0d in %0s", i_check_kind, i_check_name);
				end
			endcase
		end
	end

endmodule

// ==== verif/tb_machine_csr.sv ====
// Machine CSR testbench
`timescale 1ns/1ns

module tb_machine_csr;
	localparam int FREQUENCY = 4000;
	localparam int WAIT_LIMIT = 20;

	logic i_clock;
	logic i_reset;
	logic i_timer_interrupt;
	logic i_external_interrupt;
	logic i_ecall;
	logic i_mret;
	logic [11:0] i_index;
	logic [31:0] o_rdata;
	logic i_wdata_wr;
	logic [31:0] i_wdata;
	logic [31:0] o_epc;
	logic o_irq_pending;
	logic [31:0] o_irq_pc;
	logic i_irq_dispatched;
	logic [31:0] i_irq_epc;
	logic [63:0] i_retired;

	// Request to the checker.
	logic check_valid;
	logic [2:0] check_kind;
	logic [31:0] check_data;
	logic [31:0] check_expected;
	logic [127:0] check_name;
	int error_count;
	int check_count;

	// Current vector line.
	logic [63:0] op;
	logic [11:0] index;
	logic [31:0] data;
	logic [31:0] expected;
	logic [127:0] name;
	logic [8*120-1:0] header;
	int fd;
	int fields;
	int status;
	int op_errors;
	int timeout_count;

	machine_csr #(
		.FREQUENCY(FREQUENCY),
		.VENDORID(32'h0000_0a11),
		.ARCHID(32'h0000_0018),
		.IMPID(32'h0001_0203),
		.HARTID(32'h0000_0003)
	) i_machine_csr (.*);

	csr_checker #(
		.FREQUENCY(FREQUENCY)
	) u_checker (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rdata(o_rdata),
		.i_epc(o_epc),
		.i_irq_pc(o_irq_pc),
		.i_irq_pending(o_irq_pending),
		.i_check_valid(check_valid),
		.i_check_kind(check_kind),
		.i_check_data(check_data),
		.i_check_expected(check_expected),
		.i_check_name(check_name),
		.o_error_count(error_count),
		.o_check_count(check_count)
	);

	initial begin
		i_clock = 1'b0;
		forever #4 i_clock = ~i_clock;
	end

	// Strobes last one cycle.
	task automatic next_cycle();
		@(posedge i_clock);
		#1;
		i_wdata_wr = 1'b0;
		{i_ecall, i_external_interrupt, i_timer_interrupt} = 3'b000;
		i_mret = 1'b0;
		i_irq_dispatched = 1'b0;
		check_valid = 1'b0;
	endtask

	task automatic request_check(input logic [2:0] kind);
		check_valid = 1'b1;
		check_kind = kind;
		check_data = data;
		check_expected = expected;
		check_name = name;
		next_cycle();
	endtask

	task automatic wait_for_issue();
		int cycles;
		cycles = 0;
		while (!o_irq_pending && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (!o_irq_pending) begin
			timeout_count++;
			$display("No interrupt issued within %0d cycles in %0s", WAIT_LIMIT, name);
		end
	endtask

	task automatic run_operation();
		i_index = index;
		case (op)
			"write": begin
				i_wdata = data;
				i_wdata_wr = 1'b1;
				next_cycle();
				request_check(3'd0);
			end
			"read": request_check(3'd0);
			"cycle": request_check(3'd1);
			"time": request_check(3'd2);
			"retire": begin
				i_retired = {data, expected};
				request_check(3'd0);
			end
			"pulse": begin
				{i_ecall, i_external_interrupt, i_timer_interrupt} = data[2:0];
				next_cycle();
			end
			"issue": begin
				wait_for_issue();
				if (timeout_count == 0) begin
					request_check(3'd3);
				end
			end
			"dispatch": begin
				i_irq_epc = data;
				i_irq_dispatched = 1'b1;
				next_cycle();
				request_check(3'd4);
			end
			"mret": begin
				i_mret = 1'b1;
				next_cycle();
				request_check(3'd0);
			end
			"level": request_check(3'd5);
			"wait": repeat (data) next_cycle();
			default: begin
				op_errors++;
				$display("Unknown operation %0s in vector %0s", op, name);
			end
		endcase
	endtask

	initial begin
		i_reset = 1'b1;
		{i_timer_interrupt, i_external_interrupt, i_ecall, i_mret} = 4'b0000;
		i_index = 12'h000;
		i_wdata_wr = 1'b0;
		i_wdata = 32'd0;
		i_irq_dispatched = 1'b0;
		i_irq_epc = 32'd0;
		i_retired = 64'd0;
		{check_valid, check_kind, check_data, check_expected, check_name} = '0;
		op_errors = 0;
		timeout_count = 0;
		repeat (2) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		fd = $fopen("verif/machine_csr_vectors.txt", "r");
		if (fd == 0) begin
			op_errors++;
			$display("Could not open the vector file");
		end else begin
			status = $fgets(header, fd);
			status = $fgets(header, fd);
			if (status == 0) begin
				op_errors++;
				$display("Vector file ends within its header lines");
			end
			while (!$feof(fd) && timeout_count == 0) begin
				fields = $fscanf(fd, "%s %h %h %h %s\n", op, index, data, expected, name);
				if (fields == 5) begin
					run_operation();
				end else if (fields > 0) begin
					op_errors++;
					$display("Vector line with %0d of 5 fields after %0s", fields, name);
				end
			end
			$fclose(fd);
		end
		next_cycle();
		$display("Checks %0d, errors %0d, bad operations %0d, timeouts %0d",
			check_count, error_count, op_errors, timeout_count);
		if (error_count == 0 && op_errors == 0 && timeout_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== machine_csr.f ====
design/csr_pkg.sv
design/csr_irq_if.sv
design/csr_counters.sv
design/csr_interrupt_unit.sv
design/csr_register_file.sv
design/machine_csr.sv
verif/csr_checker.sv
verif/tb_machine_csr.sv

// ==== verif/machine_csr_vectors.txt ====
# op index data expected name
# data is the write value, pulse mask {ecall,ext,timer}, irq pc, epc, wait count or retired high word
write 305 00001000 00001000 mtvec
write 340 cafef00d cafef00d mscratch
write 304 ffffffff 00000888 mie
write 300 ffffffff 00000008 mstatus
read f11 0 00000a11 vendorid
read f12 0 00000018 archid
read f13 0 00010203 impid
read f14 0 00000003 hartid
read 7c0 0 00000000 unknown
wait 0 7 0 idle
cycle c00 0 0 cycle
time c01 0 0 time
retire c02 00000012 89abcdef instret
read c82 0 00000012 instreth
pulse 0 1 0 timer_pulse
issue 342 00001000 80000080 timer_issue
read 300 0 00000010 mstatus_taken
dispatch 344 00000abc 00000000 timer_dispatch
mret 300 0 00000008 timer_mret
pulse 0 3 0 ext_timer_pulse
issue 342 00001000 80000800 ext_issue
dispatch 344 00000b00 00000080 ext_dispatch
mret 300 0 00000008 ext_mret
issue 342 00001000 80000080 timer2_issue
dispatch 344 00000b04 00000000 timer2_dispatch
mret 300 0 00000008 timer2_mret
pulse 0 4 0 ecall_pulse
issue 342 00001000 00000800 sw_issue
dispatch 344 00000b08 00000000 sw_dispatch
mret 300 0 00000008 sw_mret
write 304 00000808 00000808 mask_timer
pulse 0 1 0 timer_masked
read 344 0 00000000 mip_masked
level 0 0 0 masked_idle
write 304 00000888 00000888 unmask_timer
write 300 00000000 00000000 clear_mie
pulse 0 1 0 timer_held
read 344 0 00000080 mip_held
level 0 0 0 held_idle
write 300 00000008 00000008 set_mie
issue 342 00001000 80000080 held_issue
dispatch 344 00000c00 00000000 held_dispatch
cycle c00 0 0 cycle_end
time c01 0 0 time_end
